// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f verilog.f --top-module tb_bt_link -Mdir obj_dir
	out="$$(./obj_dir/Vtb_bt_link)"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

// File: bt_link_top.sv
// Bluetooth link controller top
// Ties the control FSM to the stream queues, UART transmitter and response receiver
`timescale 1ns/1ps

module bt_link_top #(
	parameter int CYCLES_PER_BIT = 8,
	parameter int GAP_CYCLES = 20,
	parameter int QUEUE_DEPTH = 4,
	parameter int RESPONSE_DEPTH = 8
) (
	input  logic clock,
	input  logic reset,
	input  logic sample_valid,
	input  logic [link_pkg::STREAM_SEL_W-1:0] sample_channel,
	input  logic [7:0] sample_byte,
	input  logic [7:0] command_byte,
	input  logic want_command,
	input  logic send_streams,
	input  logic user_data_loaded,
	input  logic user_knows_stored,
	input  logic user_data_done,
	input  logic read_request,
	input  logic user_received,
	input  logic finished_reading,
	input  logic rxd,
	output logic txd,
	output logic command_stored,
	output logic response_valid,
	output logic [7:0] response_command,
	output logic [7:0] response_operand
);
	import uart_pkg::*;

	// Datapath status
	logic any_stream;
	logic command_waiting;
	logic tx_done;
	logic response_ready;

	// Control strobes
	logic command_push;
	logic source_pop;
	logic tx_start;
	logic response_pop;

	logic [7:0] tx_byte;
	response_word_t response_word;

	link_control #(.GAP_CYCLES(GAP_CYCLES)) link_control_inst (.*);

	stream_queues #(.QUEUE_DEPTH(QUEUE_DEPTH)) stream_queues_inst (.*);

	uart_transmitter #(.CYCLES_PER_BIT(CYCLES_PER_BIT)) uart_transmitter_inst (.*);

	response_receiver #(
		.CYCLES_PER_BIT(CYCLES_PER_BIT),
		.RESPONSE_DEPTH(RESPONSE_DEPTH)
	) response_receiver_inst (.*);

	// Head response word split for the user
	assign response_command = response_word.fields.command;
	assign response_operand = response_word.fields.operand;

endmodule

// File: link_control.sv
// Link control FSM
// Sequences command loading, byte transmission with an inter-byte gap
// and the response read handshake with the user
`timescale 1ns/1ps

module link_control #(
	parameter int GAP_CYCLES = 20
) (
	input  logic clock,
	input  logic reset,
	input  logic want_command,
	input  logic send_streams,
	input  logic user_data_loaded,
	input  logic user_knows_stored,
	input  logic user_data_done,
	input  logic read_request,
	input  logic user_received,
	input  logic finished_reading,
	input  logic any_stream,
	input  logic command_waiting,
	input  logic tx_done,
	input  logic response_ready,
	output logic command_push,
	output logic source_pop,
	output logic tx_start,
	output logic response_pop,
	output logic command_stored,
	output logic response_valid
);
	import link_pkg::*;

	localparam int GAP_W = $clog2(GAP_CYCLES + 1);

	link_state_t state;
	link_state_t next_state;
	logic [GAP_W-1:0] gap_count;
	logic gap_done;
	logic more_data;

	// Last cycle of the gap
	assign gap_done = (gap_count == GAP_W'(GAP_CYCLES - 1));

	// Remaining data depends on which source is active
	assign more_data = want_command ? command_waiting : any_stream;

	always_comb
	begin
		next_state = state;
		case (state)
			IDLE:
			begin
				if (want_command && user_data_loaded)
					next_state = LOAD_CMD;
				else if (!want_command && send_streams && any_stream)
					next_state = LOAD_TX;
			end
			LOAD_CMD:
				next_state = REST_CMD;
			REST_CMD:
			begin
				// Hold until the user has seen the store
				if (user_knows_stored)
					next_state = user_data_done ? LOAD_TX : IDLE;
			end
			LOAD_TX:
				next_state = SEND_TX;
			SEND_TX:
			begin
				if (tx_done)
					next_state = REST_TX;
			end
			REST_TX:
			begin
				if (gap_done)
				begin
					if (more_data)
						next_state = LOAD_TX;
					else if (want_command)
						next_state = WAIT_RESPONSE;
					else
						next_state = IDLE;
				end
			end
			WAIT_RESPONSE:
			begin
				if (response_ready)
					next_state = WAIT_REQUEST;
			end
			WAIT_REQUEST:
			begin
				if (read_request)
					next_state = READ_RESPONSE;
			end
			READ_RESPONSE:
				next_state = REST_RESPONSE;
			REST_RESPONSE:
			begin
				if (user_received)
					next_state = finished_reading ? IDLE : WAIT_REQUEST;
			end
			default:
				next_state = IDLE;
		endcase
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			state <= IDLE;
		else
			state <= next_state;
	end

	// Gap timer runs only while resting after a frame
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			gap_count <= '0;
		else if (state == REST_TX)
			gap_count <= gap_count + 1'b1;
		else
			gap_count <= '0;
	end

	// Strobes and status levels decoded from the state
	assign command_push = (state == LOAD_CMD);
	assign source_pop = (state == LOAD_TX);
	assign tx_start = (state == LOAD_TX);
	assign response_pop = (state == READ_RESPONSE);
	assign command_stored = (state == REST_CMD);
	assign response_valid = (state == REST_RESPONSE);

	// Transmitter only finishes a frame while control waits for it
	assert property (@(posedge clock) disable iff (reset) tx_done |-> (state == SEND_TX))
		else $error("tx_done outside SEND_TX");

endmodule

// File: link_pkg.sv
// Link controller definitions
// Channel count, channel index width and the control FSM state encoding

package link_pkg;

	// Sensor channels feeding the stream queues
	localparam int STREAM_COUNT = 8;
	localparam int STREAM_SEL_W = 3;

	// Control FSM states
	// Upper bits group the phase: command load, transmit, response read
	typedef enum logic [3:0] {
		IDLE          = 4'b0000,
		LOAD_CMD      = 4'b0010,
		REST_CMD      = 4'b0011,
		LOAD_TX       = 4'b0100,
		SEND_TX       = 4'b0101,
		REST_TX       = 4'b0110,
		WAIT_RESPONSE = 4'b1000,
		WAIT_REQUEST  = 4'b1101,
		READ_RESPONSE = 4'b1110,
		REST_RESPONSE = 4'b1111
	} link_state_t;

endpackage

// File: response_receiver.sv
// Response receiver
// Deserializes the radio's UART line, pairs bytes into command/operand words
// and queues them, flagging a complete line once LINE_END is stored
`timescale 1ns/1ps

module response_receiver #(
	parameter int CYCLES_PER_BIT = 8,
	parameter int RESPONSE_DEPTH = 8
) (
	input  logic clock,
	input  logic reset,
	input  logic rxd,
	input  logic response_pop,
	output uart_pkg::response_word_t response_word,
	output logic response_ready
);
	import uart_pkg::*;

	localparam int HALF_BIT = CYCLES_PER_BIT / 2;
	localparam int TIMER_W = $clog2(CYCLES_PER_BIT + 1);
	localparam int INDEX_W = $clog2(FRAME_BITS);
	localparam int PTR_W = $clog2(RESPONSE_DEPTH);
	localparam int CNT_W = $clog2(RESPONSE_DEPTH + 1);

	logic [1:0] rx_sync;
	logic rx_line;
	logic rx_busy;
	logic [TIMER_W-1:0] bit_timer;
	logic [INDEX_W-1:0] bit_index;
	logic sample_now;
	logic [DATA_BITS-1:0] rx_shift;
	logic byte_valid;
	logic have_first;
	logic [7:0] first_byte;
	logic is_line_end;
	logic push_en;
	logic push_store;
	response_word_t push_word;
	logic [15:0] resp_mem [RESPONSE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] resp_count;
	logic line_seen;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(RESPONSE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Two-flop synchronizer, line idles high
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			rx_sync <= 2'b11;
		else
			rx_sync <= {rx_sync[0], rxd};
	end
	assign rx_line = rx_sync[1];

	// Start bit checked at half a bit, the rest at whole bit steps
	assign sample_now = rx_busy && (bit_timer == ((bit_index == '0) ?
		TIMER_W'(HALF_BIT - 1) : TIMER_W'(CYCLES_PER_BIT - 1)));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			rx_busy <= 1'b0;
			bit_timer <= '0;
			bit_index <= '0;
			byte_valid <= 1'b0;
		end
		else
		begin
			byte_valid <= 1'b0;
			if (!rx_busy)
			begin
				if (rx_line == START_BIT)
				begin
					rx_busy <= 1'b1;
					bit_timer <= '0;
					bit_index <= '0;
				end
			end
			else if (sample_now)
			begin
				bit_timer <= '0;
				bit_index <= bit_index + 1'b1;
				// Glitch on the line, not a real start bit
				if (bit_index == '0 && rx_line != START_BIT)
					rx_busy <= 1'b0;
				else if (bit_index == INDEX_W'(FRAME_BITS - 1))
				begin
					rx_busy <= 1'b0;
					byte_valid <= (rx_line == STOP_BIT);
				end
			end
			else
				bit_timer <= bit_timer + 1'b1;
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge clock)
	begin
		if (sample_now && bit_index != '0 && bit_index <= INDEX_W'(DATA_BITS))
			rx_shift <= {rx_line, rx_shift[DATA_BITS-1:1]};
	end

	// Pair up bytes, a lone LINE_END closes the pair early
	assign is_line_end = (rx_shift == LINE_END);
	assign push_en = byte_valid && (have_first || is_line_end);
	assign push_store = push_en && (resp_count != CNT_W'(RESPONSE_DEPTH));

	always_comb
	begin
		push_word.fields.command = have_first ? first_byte : rx_shift;
		push_word.fields.operand = have_first ? rx_shift : 8'h00;
	end

	always_ff @(posedge clock)
	begin
		if (byte_valid && !have_first)
			first_byte <= rx_shift;
		if (push_store)
			resp_mem[wr_ptr] <= push_word.raw;
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			have_first <= 1'b0;
			wr_ptr <= '0;
			rd_ptr <= '0;
			resp_count <= '0;
			line_seen <= 1'b0;
		end
		else
		begin
			if (byte_valid)
				have_first <= !have_first && !is_line_end;
			if (push_store)
				wr_ptr <= next_ptr(wr_ptr);
			if (response_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (push_store && !response_pop)
				resp_count <= resp_count + 1'b1;
			else if (response_pop && !push_store)
				resp_count <= resp_count - 1'b1;
			// Line stays ready until the last word is read out
			if (push_store && is_line_end)
				line_seen <= 1'b1;
			else if (response_pop && !push_store && resp_count == CNT_W'(1))
				line_seen <= 1'b0;
		end
	end

	assign response_word = response_word_t'(resp_mem[rd_ptr]);
	assign response_ready = line_seen;

	// Reads only happen after a full line has been queued
	assert property (@(posedge clock) disable iff (reset) response_pop |-> resp_count != '0)
		else $error("response_pop on an empty response queue");

endmodule

// File: stream_queues.sv
// Stream and command queues
// Eight channel FIFOs plus the command FIFO, with a rotating channel
// selector that feeds the head byte of the active source to the transmitter
`timescale 1ns/1ps

module stream_queues #(
	parameter int QUEUE_DEPTH = 4
) (
	input  logic clock,
	input  logic reset,
	input  logic sample_valid,
	input  logic [link_pkg::STREAM_SEL_W-1:0] sample_channel,
	input  logic [7:0] sample_byte,
	input  logic command_push,
	input  logic [7:0] command_byte,
	input  logic want_command,
	input  logic source_pop,
	output logic [7:0] tx_byte,
	output logic any_stream,
	output logic command_waiting
);
	import link_pkg::*;

	// Channels first, command queue in the last slot
	localparam int QUEUE_COUNT = STREAM_COUNT + 1;
	localparam int CMD_INDEX = STREAM_COUNT;
	localparam int SRC_W = $clog2(QUEUE_COUNT);
	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [7:0] head [QUEUE_COUNT];
	logic [QUEUE_COUNT-1:0] nonempty;
	logic [STREAM_SEL_W-1:0] stream_ptr;
	logic [STREAM_SEL_W-1:0] stream_pick;
	logic [STREAM_SEL_W-1:0] stream_cand;
	logic stream_found;
	logic [SRC_W-1:0] source_index;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	for (genvar i = 0; i < QUEUE_COUNT; i++)
	begin : gen_queue
		logic [7:0] mem [QUEUE_DEPTH];
		logic [PTR_W-1:0] wr_ptr;
		logic [PTR_W-1:0] rd_ptr;
		logic [CNT_W-1:0] count;
		logic full;
		logic push;
		logic pop;
		logic [7:0] push_byte;

		assign full = (count == CNT_W'(QUEUE_DEPTH));

		if (i == CMD_INDEX)
		begin : gen_cmd
			assign push = command_push && !full;
			assign push_byte = command_byte;
		end
		else
		begin : gen_chan
			// A sample for a full channel is lost
			assign push = sample_valid && !full
				&& (sample_channel == STREAM_SEL_W'(i));
			assign push_byte = sample_byte;
		end

		assign pop = source_pop && (source_index == SRC_W'(i));
		assign nonempty[i] = (count != '0);
		assign head[i] = mem[rd_ptr];

		always_ff @(posedge clock)
		begin
			if (push)
				mem[wr_ptr] <= push_byte;
		end

		always_ff @(posedge clock or posedge reset)
		begin
			if (reset)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end
			else
			begin
				if (push)
					wr_ptr <= next_ptr(wr_ptr);
				if (pop)
					rd_ptr <= next_ptr(rd_ptr);
				if (push && !pop)
					count <= count + 1'b1;
				else if (pop && !push)
					count <= count - 1'b1;
			end
		end
	end

	// First non-empty channel at or after the rotating pointer
	always_comb
	begin
		stream_found = 1'b0;
		stream_pick = stream_ptr;
		stream_cand = stream_ptr;
		for (int k = 0; k < STREAM_COUNT; k++)
		begin
			stream_cand = stream_ptr + STREAM_SEL_W'(k);
			if (!stream_found && nonempty[stream_cand])
			begin
				stream_pick = stream_cand;
				stream_found = 1'b1;
			end
		end
	end

	// Next turn starts one past the channel just served
	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
			stream_ptr <= '0;
		else if (source_pop && !want_command)
			stream_ptr <= stream_pick + 1'b1;
	end

	assign source_index = want_command ? SRC_W'(CMD_INDEX) : SRC_W'(stream_pick);
	assign tx_byte = head[source_index];
	assign any_stream = |nonempty[STREAM_COUNT-1:0];
	assign command_waiting = nonempty[CMD_INDEX];

	// Control only pops after seeing data in the active source
	assert property (@(posedge clock) disable iff (reset) source_pop |-> nonempty[source_index])
		else $error("source_pop on an empty source");

endmodule

// File: tb_bt_link.sv
// Testbench for the Bluetooth link controller
// Streams sensor bytes, runs a command/response exchange and checks the serial traffic
`timescale 1ns/1ps

module tb_bt_link;
	import link_pkg::*;
	import uart_pkg::*;

	localparam int CYCLES_PER_BIT = 8;
	localparam int GAP_CYCLES = 20;
	localparam int QUEUE_DEPTH = 4;
	localparam int RESPONSE_DEPTH = 8;
	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES
		+ 64 * (FRAME_BITS * CYCLES_PER_BIT + GAP_CYCLES + 8) + 500;
	// Earliest start-to-start spacing of two frames on txd
	localparam time FRAME_SPACING = time'((FRAME_BITS * CYCLES_PER_BIT + GAP_CYCLES) * PERIOD);

	localparam logic [7:0] COMMAND_BYTES [3] = '{8'h41, 8'h54, 8'h0D};
	// Odd length, so the terminator ends up alone in the last word
	localparam logic [7:0] RESPONSE_LINE [5] = '{8'h4F, 8'h4B, 8'h2B, 8'h33, LINE_END};

	logic clock;
	logic reset;
	logic sample_valid;
	logic [STREAM_SEL_W-1:0] sample_channel;
	logic [7:0] sample_byte;
	logic [7:0] command_byte;
	logic want_command;
	logic send_streams;
	logic user_data_loaded;
	logic user_knows_stored;
	logic user_data_done;
	logic read_request;
	logic user_received;
	logic finished_reading;
	logic rxd;
	logic txd;
	logic command_stored;
	logic response_valid;
	logic [7:0] response_command;
	logic [7:0] response_operand;

	integer seed;
	int cycle_count;
	logic [7:0] expected_tx [$];
	response_word_t expected_resp [$];

	// Reference copy of the channel queues and the rotating pointer
	logic [7:0] model_data [STREAM_COUNT][QUEUE_DEPTH];
	int model_count [STREAM_COUNT];
	int model_ptr;

	bt_link_top #(
		.CYCLES_PER_BIT(CYCLES_PER_BIT),
		.GAP_CYCLES(GAP_CYCLES),
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.RESPONSE_DEPTH(RESPONSE_DEPTH)
	) bt_link_top_inst (.*);

	initial
	begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	task automatic fail_with(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic fail_mismatch(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		fail_with($sformatf("Mismatch at %0t: %s expected 0x%0h, got 0x%0h",
			$time, name, expected, actual));
	endtask

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			fail_with("Timeout: the run did not finish within the cycle limit");
	end

	assert property (@(posedge clock) reset |-> (txd && !command_stored && !response_valid))
		else fail_with("Outputs are not in their reset state while reset is high");
	assert property (@(posedge clock) disable iff (reset)
		command_stored && !user_knows_stored |=> command_stored)
		else fail_with("command_stored dropped before the user acknowledged it");
	assert property (@(posedge clock) disable iff (reset)
		response_valid && !user_received |=> response_valid)
		else fail_with("response_valid dropped before the user acknowledged the word");
	assert property (@(posedge clock) disable iff (reset) !(command_stored && response_valid))
		else fail_with("command_stored and response_valid high together");

	// Serial line model on txd, decodes each frame at the bit midpoints
	initial
	begin : txd_monitor
		logic [7:0] data;
		logic [7:0] expected_byte;
		time start_time;
		time last_start;
		bit have_last;
		have_last = 1'b0;
		last_start = 0;
		forever
		begin
			@(posedge clock);
			if (!reset && txd === 1'b0)
			begin
				start_time = $time;
				if (have_last)
					assert ((start_time - last_start) >= FRAME_SPACING)
						else fail_with($sformatf("Only %0d idle cycles on txd before the frame at %0t",
							(start_time - last_start) / PERIOD - FRAME_BITS * CYCLES_PER_BIT, start_time));
				have_last = 1'b1;
				last_start = start_time;
				repeat (CYCLES_PER_BIT / 2) @(posedge clock);
				for (int i = 0; i < 8; i++)
				begin
					repeat (CYCLES_PER_BIT) @(posedge clock);
					data[i] = txd;
				end
				repeat (CYCLES_PER_BIT) @(posedge clock);
				assert (txd === 1'b1)
					else fail_mismatch("txd stop bit", 16'(1), 16'(txd));
				assert (expected_tx.size() != 0)
					else fail_with($sformatf("Unexpected frame 0x%02h on txd at %0t", data, $time));
				expected_byte = expected_tx.pop_front();
				assert (data == expected_byte)
					else fail_mismatch("txd", 16'(expected_byte), 16'(data));
			end
		end
	end

	task automatic load_sample(input logic [STREAM_SEL_W-1:0] channel);
		logic [7:0] value;
		value = 8'($random(seed));
		@(posedge clock);
		sample_valid <= 1'b1;
		sample_channel <= channel;
		sample_byte <= value;
		// A full channel drops the sample
		if (model_count[channel] < QUEUE_DEPTH)
		begin
			model_data[channel][model_count[channel]] = value;
			model_count[channel]++;
		end
		@(posedge clock);
		sample_valid <= 1'b0;
	endtask

	// Drains the reference queues in rotation order into the expected frames
	task automatic schedule_stream_bytes();
		int pending;
		int pick;
		pending = 0;
		for (int c = 0; c < STREAM_COUNT; c++)
			pending += model_count[c];
		repeat (pending)
		begin
			pick = -1;
			for (int k = 0; k < STREAM_COUNT; k++)
			begin
				if (pick < 0 && model_count[(model_ptr + k) % STREAM_COUNT] != 0)
					pick = (model_ptr + k) % STREAM_COUNT;
			end
			expected_tx.push_back(model_data[pick][0]);
			for (int d = 1; d < QUEUE_DEPTH; d++)
				model_data[pick][d-1] = model_data[pick][d];
			model_count[pick]--;
			model_ptr = (pick + 1) % STREAM_COUNT;
		end
	endtask

	// Rest of the stop bit plus the inter-byte gap
	task automatic wait_link_idle();
		repeat (CYCLES_PER_BIT + GAP_CYCLES + 4) @(posedge clock);
	endtask

	task automatic wait_tx_drained();
		while (expected_tx.size() != 0)
			@(posedge clock);
		wait_link_idle();
	endtask

	task automatic store_command(input logic [7:0] value, input logic last);
		@(posedge clock);
		command_byte <= value;
		user_data_loaded <= 1'b1;
		user_data_done <= last;
		do
			@(posedge clock);
		while (command_stored !== 1'b1);
		expected_tx.push_back(value);
		// User takes a while to notice
		repeat (3) @(posedge clock);
		user_knows_stored <= 1'b1;
		user_data_loaded <= 1'b0;
		do
			@(posedge clock);
		while (command_stored === 1'b1);
		user_knows_stored <= 1'b0;
		user_data_done <= 1'b0;
	endtask

	task automatic send_serial_byte(input logic [7:0] value);
		logic [FRAME_BITS-1:0] frame;
		frame = {1'b1, value, 1'b0};
		for (int b = 0; b < FRAME_BITS; b++)
		begin
			@(posedge clock);
			rxd <= frame[b];
			repeat (CYCLES_PER_BIT - 1) @(posedge clock);
		end
		repeat (2 * CYCLES_PER_BIT) @(posedge clock);
	endtask

	// Byte pairs become command/operand words, a lone terminator gets operand zero
	task automatic expect_response_line();
		response_word_t word;
		logic [7:0] first;
		bit have_first;
		have_first = 1'b0;
		first = 8'h00;
		for (int i = 0; i < $size(RESPONSE_LINE); i++)
		begin
			if (have_first)
			begin
				word.fields.command = first;
				word.fields.operand = RESPONSE_LINE[i];
				expected_resp.push_back(word);
				have_first = 1'b0;
			end
			else if (RESPONSE_LINE[i] == LINE_END)
			begin
				word.fields.command = LINE_END;
				word.fields.operand = 8'h00;
				expected_resp.push_back(word);
			end
			else
			begin
				first = RESPONSE_LINE[i];
				have_first = 1'b1;
			end
		end
	endtask

	task automatic read_responses();
		response_word_t word;
		while (expected_resp.size() != 0)
		begin
			word = expected_resp.pop_front();
			assert (response_command == word.fields.command)
				else fail_mismatch("response_command", 16'(word.fields.command), 16'(response_command));
			assert (response_operand == word.fields.operand)
				else fail_mismatch("response_operand", 16'(word.fields.operand), 16'(response_operand));
			@(posedge clock);
			read_request <= 1'b1;
			do
				@(posedge clock);
			while (response_valid !== 1'b1);
			read_request <= 1'b0;
			user_received <= 1'b1;
			finished_reading <= (expected_resp.size() == 0);
			do
				@(posedge clock);
			while (response_valid === 1'b1);
			user_received <= 1'b0;
			finished_reading <= 1'b0;
		end
	endtask

	initial
	begin
		seed = 32'haee7;
		cycle_count = 0;
		model_ptr = 0;
		for (int c = 0; c < STREAM_COUNT; c++)
			model_count[c] = 0;
		reset = 1'b1;
		sample_valid = 1'b0;
		sample_channel = '0;
		sample_byte = 8'h00;
		command_byte = 8'h00;
		want_command = 1'b0;
		send_streams = 1'b0;
		user_data_loaded = 1'b0;
		user_knows_stored = 1'b0;
		user_data_done = 1'b0;
		read_request = 1'b0;
		user_received = 1'b0;
		finished_reading = 1'b0;
		rxd = 1'b1;

		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		assert (txd === 1'b1)
			else fail_mismatch("txd", 16'(1), 16'(txd));
		assert (command_stored === 1'b0)
			else fail_mismatch("command_stored", 16'(0), 16'(command_stored));
		assert (response_valid === 1'b0)
			else fail_mismatch("response_valid", 16'(0), 16'(response_valid));

		// Fill several channels while sending is off, channel 2 overflows
		repeat (5) load_sample(3'd2);
		load_sample(3'd5);
		repeat (2) load_sample(3'd0);
		repeat (2) load_sample(3'd7);
		schedule_stream_bytes();
		@(posedge clock);
		send_streams <= 1'b1;
		wait_tx_drained();

		@(posedge clock);
		send_streams <= 1'b0;
		want_command <= 1'b1;
		for (int i = 0; i < $size(COMMAND_BYTES); i++)
			store_command(COMMAND_BYTES[i], i == $size(COMMAND_BYTES) - 1);
		wait_tx_drained();

		// Radio answers once the command is out
		expect_response_line();
		for (int i = 0; i < $size(RESPONSE_LINE); i++)
			send_serial_byte(RESPONSE_LINE[i]);
		read_responses();

		// Back in stream mode after the read session
		@(posedge clock);
		want_command <= 1'b0;
		send_streams <= 1'b1;
		load_sample(3'd4);
		schedule_stream_bytes();
		wait_tx_drained();

		if (expected_tx.size() == 0 && expected_resp.size() == 0)
		begin
			$display("Simulation passed");
			$finish;
		end
		else
			fail_with("Expected traffic still outstanding at the end of the run");
	end

endmodule

// File: uart_pkg.sv
// Serial framing definitions
// 8N1 frame layout, line terminator and the response word layout

package uart_pkg;

	// 8N1 frame: start, eight data bits LSB first, stop
	localparam int DATA_BITS = 8;
	localparam int FRAME_BITS = DATA_BITS + 2;

	// Line levels, idle line sits at the stop level
	localparam logic START_BIT = 1'b0;
	localparam logic STOP_BIT = 1'b1;

	// Radio response lines end with a newline
	localparam logic [7:0] LINE_END = 8'h0A;

	// One stored response word
	// First received byte is the command, second the operand
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [7:0] operand;
			logic [7:0] command;
		} fields;
	} response_word_t;

endpackage

// File: uart_transmitter.sv
// UART transmitter
// Sends one 8N1 frame per tx_start, each bit CYCLES_PER_BIT clocks long
`timescale 1ns/1ps

module uart_transmitter #(
	parameter int CYCLES_PER_BIT = 8
) (
	input  logic clock,
	input  logic reset,
	input  logic tx_start,
	input  logic [7:0] tx_byte,
	output logic txd,
	output logic tx_done
);
	import uart_pkg::*;

	localparam int TIMER_W = $clog2(CYCLES_PER_BIT + 1);
	localparam int INDEX_W = $clog2(FRAME_BITS);

	logic busy;
	logic [TIMER_W-1:0] bit_timer;
	logic [INDEX_W-1:0] bit_index;
	logic [FRAME_BITS-1:0] frame;
	logic bit_end;

	assign bit_end = (bit_timer == TIMER_W'(CYCLES_PER_BIT - 1));
	assign tx_done = busy && bit_end && (bit_index == INDEX_W'(FRAME_BITS - 1));

	// Idle line rests at the stop level
	assign txd = busy ? frame[0] : STOP_BIT;

	// Whole frame latched at start, bit 0 is on the line
	always_ff @(posedge clock)
	begin
		if (tx_start)
			frame <= {STOP_BIT, tx_byte, START_BIT};
		else if (busy && bit_end)
			frame <= {STOP_BIT, frame[FRAME_BITS-1:1]};
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			bit_timer <= '0;
			bit_index <= '0;
		end
		else if (tx_start)
		begin
			busy <= 1'b1;
			bit_timer <= '0;
			bit_index <= '0;
		end
		else if (busy)
		begin
			if (bit_end)
			begin
				bit_timer <= '0;
				bit_index <= bit_index + 1'b1;
				if (tx_done)
					busy <= 1'b0;
			end
			else
				bit_timer <= bit_timer + 1'b1;
		end
	end

	// Control waits for tx_done before the next start
	assert property (@(posedge clock) disable iff (reset) tx_start |-> !busy)
		else $error("tx_start during a frame");

endmodule

// File: verilog.f
link_pkg.sv
uart_pkg.sv
link_control.sv
stream_queues.sv
uart_transmitter.sv
response_receiver.sv
bt_link_top.sv
tb_bt_link.sv
